//--- gpio_apb_subsys.f
hw/gpio_pkg.sv
hw/gpio_input_sync.sv
hw/gpio_irq_detect.sv
hw/gpio_pad_ctrl.sv
hw/apb_gpio_regs.sv
hw/apb_gpio.sv
tests/apb_gpio_sva.sv
tests/tb_apb_gpio.sv

//--- tests/tb_apb_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module tb_apb_gpio;

  localparam int N_GPIO     = 32;
  localparam int CLK_PERIOD = 40;
  localparam int N_XFER     = 200;  // transfer budget
  localparam int XFER_CYC   = 3;    // setup, access, idle
  localparam int MARGIN_CYC = 200;
  localparam int TIMEOUT_NS = (N_XFER * XFER_CYC + MARGIN_CYC) * CLK_PERIOD;
  localparam logic [N_GPIO-1:0] IRQ_PINS = 32'h0000_3288;  // pins 3 7 9 12 13

  logic              HCLK;
  logic              HRESETn;
  logic [11:0]       PADDR;
  logic [31:0]       PWDATA;
  logic              PWRITE;
  logic              PSEL;
  logic              PENABLE;
  logic [31:0]       PRDATA;
  logic              PREADY;
  logic              PSLVERR;
  logic [N_GPIO-1:0] gpio_in;
  logic [N_GPIO-1:0] gpio_in_sync;
  logic [N_GPIO-1:0] gpio_out;
  logic [N_GPIO-1:0] gpio_dir;
  logic [N_GPIO-1:0] interrupt;

  logic [31:0]       rng;
  int                errors;
  logic [N_GPIO-1:0] ref_out;
  logic [1:0]        ref_dir [N_GPIO];
  logic [2:0]        ref_type [N_GPIO];

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  apb_gpio #(
    .N_GPIO (N_GPIO),
    .ADDR_W (12)
  ) UUT (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .PADDR        (PADDR),
    .PWDATA       (PWDATA),
    .PWRITE       (PWRITE),
    .PSEL         (PSEL),
    .PENABLE      (PENABLE),
    .PRDATA       (PRDATA),
    .PREADY       (PREADY),
    .PSLVERR      (PSLVERR),
    .gpio_in      (gpio_in),
    .gpio_in_sync (gpio_in_sync),
    .gpio_out     (gpio_out),
    .gpio_dir     (gpio_dir),
    .interrupt    (interrupt)
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge HCLK);
    PADDR  <= addr;
    PWDATA <= data;
    PWRITE <= 1'b1;
    PSEL   <= 1'b1;
    @(posedge HCLK);
    PENABLE <= 1'b1;
    @(posedge HCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    @(posedge HCLK);
    PADDR  <= addr;
    PWRITE <= 1'b0;
    PSEL   <= 1'b1;
    @(posedge HCLK);
    PENABLE <= 1'b1;
    @(negedge HCLK);
    data = PRDATA;  // middle of access phase
    @(posedge HCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // expected status of a pin, input held stable long before the read
  function automatic logic [31:0] status_word(input int pin);
    logic [31:0] w;
    w = '0;
    w[gpio_pkg::RD_DIR_LO +: 2]  = ref_dir[pin];
    w[gpio_pkg::RD_TYPE_LO +: 3] = ref_type[pin];
    w[gpio_pkg::RD_IN_BIT]       = gpio_in[pin];
    w[gpio_pkg::RD_OUT_BIT]      = ref_out[pin];
    w[4:0]                       = 5'(pin);
    return w;
  endfunction

  task automatic set_dir(input int pin, input logic [1:0] mode);
    logic [31:0] wd;
    logic [31:0] rd;
    wd = 32'(pin);
    wd[gpio_pkg::FLD_DIR_LO +: 2] = mode;
    apb_write(gpio_pkg::REG_SETDIR, wd);
    ref_dir[pin] = mode;
    apb_read(gpio_pkg::REG_RDSTAT, rd);
    check_word("REG_RDSTAT after REG_SETDIR", rd, status_word(pin));
  endtask

  task automatic set_int(input int pin, input logic en, input logic [2:0] kind);
    logic [31:0] wd;
    logic [31:0] rd;
    wd = 32'(pin);
    wd[gpio_pkg::FLD_INTEN] = en;
    wd[gpio_pkg::FLD_INTTYPE_LO +: 3] = kind;
    apb_write(gpio_pkg::REG_SETINT, wd);
    ref_type[pin] = kind;
    apb_read(gpio_pkg::REG_RDSTAT, rd);
    check_word("REG_RDSTAT after REG_SETINT", rd, status_word(pin));
  endtask

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] rd;
    int          pin;
    HCLK    = 1'b0;
    HRESETn = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    PWRITE  = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    gpio_in = '0;
    rng     = 32'd68;
    errors  = 0;
    ref_out = '0;
    for (int i = 0; i < N_GPIO; i++) begin
      ref_dir[i]  = gpio_pkg::DIR_OFF;
      ref_type[i] = 3'b000;
    end
    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;

    for (int k = 0; k < 8; k++) begin  // input path
      @(posedge HCLK);
      gpio_in <= next_rand();
      repeat (3) @(posedge HCLK);
      apb_read(gpio_pkg::REG_PIN0, rd);
      check_word("REG_PIN0", rd, gpio_in);
    end

    for (int k = 0; k < 24; k++) begin  // set, clear, toggle
      r   = next_rand();
      pin = int'(r[4:0]);
      case (r[9:8])
        2'd0: begin
          apb_write(gpio_pkg::REG_SETGPIO, 32'(pin));
          ref_out[pin] = 1'b1;
        end
        2'd1: begin
          apb_write(gpio_pkg::REG_CLRGPIO, 32'(pin));
          ref_out[pin] = 1'b0;
        end
        default: begin
          apb_write(gpio_pkg::REG_TOGGPIO, 32'(pin));
          ref_out[pin] = ~ref_out[pin];
        end
      endcase
      apb_read(gpio_pkg::REG_OUT0, rd);
      check_word("REG_OUT0 after pin command", rd, ref_out);
    end
    r = next_rand();
    apb_write(gpio_pkg::REG_OUT0, r);
    ref_out = r;
    apb_read(gpio_pkg::REG_OUT0, rd);
    check_word("REG_OUT0 after bank write", rd, ref_out);

    for (int p = 0; p < 6; p++) begin  // off, push-pull, open drain
      set_dir(p, 2'(p % 3));
      apb_write(gpio_pkg::REG_TOGGPIO, 32'(p));
      ref_out[p] = ~ref_out[p];
    end

    @(posedge HCLK);
    gpio_in <= '0;
    repeat (6) @(posedge HCLK);
    set_int(3, 1'b1, 3'b010);
    set_int(7, 1'b1, 3'b001);
    set_int(9, 1'b0, 3'b010);   // rising, masked
    set_int(12, 1'b1, 3'b100);  // active high
    set_int(13, 1'b1, 3'b000);  // active low
    for (int k = 0; k < 10; k++) begin
      r = next_rand();
      @(posedge HCLK);
      if (k < 4) gpio_in <= gpio_in ^ IRQ_PINS;  // sure edges first
      else gpio_in <= r[N_GPIO-1:0] & IRQ_PINS;
      repeat (8) @(posedge HCLK);
    end

    repeat (4) @(posedge HCLK);
    $display("errors: %0d read mismatches, %0d assertion failures",
             errors, UUT.u_sva.fail_count);
    if (errors == 0 && UUT.u_sva.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog timeout: the test sequence did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/apb_gpio_sva.sv
`timescale 1ns/1ps
`default_nettype none

module apb_gpio_sva #(
  parameter int N_GPIO = 32
) (
  input wire logic                   HCLK,
  input wire logic                   HRESETn,
  input wire logic                   PREADY,
  input wire logic                   PSLVERR,
  input wire logic [N_GPIO-1:0]      gpio_in,
  input wire logic [N_GPIO-1:0]      gpio_in_sync,
  input wire logic [N_GPIO-1:0]      gpio_out,
  input wire logic [N_GPIO-1:0]      gpio_dir,
  input wire logic [N_GPIO-1:0]      interrupt,
  input wire logic [N_GPIO-1:0]      out_reg,
  input wire logic [N_GPIO-1:0][1:0] dir_mode,
  input wire logic [N_GPIO-1:0][2:0] int_type,
  input wire logic [N_GPIO-1:0]      int_en
);

  int         fail_count = 0;
  logic [1:0] edges_seen;  // history depth for $past

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      edges_seen <= '0;
    end else if (edges_seen != 2'd3) begin
      edges_seen <= edges_seen + 2'd1;
    end
  end

  a_apb_resp: assert property (@(posedge HCLK) PREADY && !PSLVERR)
    else begin
      $error("FAILED %0t: PREADY low or PSLVERR high", $time);
      fail_count++;
    end

  a_sync_lag: assert property (@(posedge HCLK) disable iff (!HRESETn)
    edges_seen == 2'd3 |-> gpio_in_sync == $past(gpio_in, 3))
    else begin
      $error("FAILED %0t: gpio_in_sync is not gpio_in delayed by 3 edges", $time);
      fail_count++;
    end

  for (genvar i = 0; i < N_GPIO; i++) begin : g_pin
    a_pad: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (dir_mode[i] == gpio_pkg::DIR_PUSH) ? (gpio_out[i] == out_reg[i] && gpio_dir[i]) :
      (dir_mode[i] == gpio_pkg::DIR_OD) ? (!gpio_out[i] && gpio_dir[i] == !out_reg[i]) :
      (!gpio_out[i] && !gpio_dir[i]))
      else begin
        $error("FAILED %0t: pad outputs wrong on pin %0d", $time, i);
        fail_count++;
      end

    a_rise: assert property (@(posedge HCLK) disable iff (!HRESETn)
      $rose(gpio_in[i]) && int_en[i] && int_type[i] == 3'b010
      |-> ##3 !interrupt[i] ##1 interrupt[i] ##1 !interrupt[i])
      else begin
        $error("FAILED %0t: rising interrupt pulse wrong on pin %0d", $time, i);
        fail_count++;
      end

    a_fall: assert property (@(posedge HCLK) disable iff (!HRESETn)
      $fell(gpio_in[i]) && int_en[i] && int_type[i] == 3'b001
      |-> ##3 !interrupt[i] ##1 interrupt[i] ##1 !interrupt[i])
      else begin
        $error("FAILED %0t: falling interrupt pulse wrong on pin %0d", $time, i);
        fail_count++;
      end

    a_masked: assert property (@(posedge HCLK) disable iff (!HRESETn)
      !int_en[i] |-> !interrupt[i])
      else begin
        $error("FAILED %0t: interrupt on disabled pin %0d", $time, i);
        fail_count++;
      end

    a_level_hi: assert property (@(posedge HCLK) disable iff (!HRESETn)
      int_en[i] && int_type[i] == 3'b100 |-> interrupt[i] == gpio_in_sync[i])
      else begin
        $error("FAILED %0t: active high level wrong on pin %0d", $time, i);
        fail_count++;
      end

    a_level_lo: assert property (@(posedge HCLK) disable iff (!HRESETn)
      int_en[i] && int_type[i] == 3'b000 |-> interrupt[i] == !gpio_in_sync[i])
      else begin
        $error("FAILED %0t: active low level wrong on pin %0d", $time, i);
        fail_count++;
      end
  end

endmodule

bind apb_gpio apb_gpio_sva #(
  .N_GPIO (N_GPIO)
) u_sva (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .PREADY       (PREADY),
  .PSLVERR      (PSLVERR),
  .gpio_in      (gpio_in),
  .gpio_in_sync (gpio_in_sync),
  .gpio_out     (gpio_out),
  .gpio_dir     (gpio_dir),
  .interrupt    (interrupt),
  .out_reg      (out_reg),
  .dir_mode     (dir_mode),
  .int_type     (int_type),
  .int_en       (int_en)
);

`default_nettype wire

//--- hw/apb_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module apb_gpio #(
  parameter int N_GPIO = 32,
  parameter int ADDR_W = 12
) (
  input  wire logic                            HCLK,
  input  wire logic                            HRESETn,
  input  wire logic [ADDR_W-1:0]               PADDR,
  input  wire logic [gpio_pkg::APB_DATA_W-1:0] PWDATA,
  input  wire logic                            PWRITE,
  input  wire logic                            PSEL,
  input  wire logic                            PENABLE,
  output logic      [gpio_pkg::APB_DATA_W-1:0] PRDATA,
  output logic                                 PREADY,
  output logic                                 PSLVERR,
  input  wire logic [N_GPIO-1:0]               gpio_in,
  output logic      [N_GPIO-1:0]               gpio_in_sync,
  output logic      [N_GPIO-1:0]               gpio_out,
  output logic      [N_GPIO-1:0]               gpio_dir,
  output logic      [N_GPIO-1:0]               interrupt
);

  logic [N_GPIO-1:0]      out_reg;
  logic [N_GPIO-1:0][1:0] dir_mode;
  logic [N_GPIO-1:0][2:0] int_type;
  logic [N_GPIO-1:0]      int_en;
  logic [N_GPIO-1:0]      rise;
  logic [N_GPIO-1:0]      fall;

  apb_gpio_regs #(
    .N_GPIO (N_GPIO),
    .ADDR_W (ADDR_W)
  ) u_regs (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .PADDR    (PADDR),
    .PWDATA   (PWDATA),
    .PWRITE   (PWRITE),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PRDATA   (PRDATA),
    .PREADY   (PREADY),
    .PSLVERR  (PSLVERR),
    .pin_sync (gpio_in_sync),
    .out_reg  (out_reg),
    .dir_mode (dir_mode),
    .int_type (int_type),
    .int_en   (int_en)
  );

  gpio_input_sync #(
    .N_GPIO (N_GPIO)
  ) u_sync (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .gpio_in  (gpio_in),
    .pin_sync (gpio_in_sync),  // pin register is the exported input
    .rise     (rise),
    .fall     (fall)
  );

  gpio_irq_detect #(
    .N_GPIO (N_GPIO)
  ) u_irq (
    .pin_sync  (gpio_in_sync),
    .rise      (rise),
    .fall      (fall),
    .int_type  (int_type),
    .int_en    (int_en),
    .interrupt (interrupt)
  );

  gpio_pad_ctrl #(
    .N_GPIO (N_GPIO)
  ) u_pad (
    .out_reg  (out_reg),
    .dir_mode (dir_mode),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir)
  );

endmodule

`default_nettype wire

//--- hw/apb_gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_gpio_regs #(
  parameter int N_GPIO = 32,
  parameter int ADDR_W = 12
) (
  input  wire logic                                HCLK,
  input  wire logic                                HRESETn,
  input  wire logic [ADDR_W-1:0]                   PADDR,
  input  wire logic [gpio_pkg::APB_DATA_W-1:0]     PWDATA,
  input  wire logic                                PWRITE,
  input  wire logic                                PSEL,
  input  wire logic                                PENABLE,
  output logic      [gpio_pkg::APB_DATA_W-1:0]     PRDATA,
  output logic                                     PREADY,
  output logic                                     PSLVERR,
  input  wire logic [N_GPIO-1:0]                   pin_sync,
  output logic      [N_GPIO-1:0]                   out_reg,
  output logic      [N_GPIO-1:0][1:0]              dir_mode,
  output logic      [N_GPIO-1:0][2:0]              int_type,
  output logic      [N_GPIO-1:0]                   int_en
);

  localparam int DW    = gpio_pkg::APB_DATA_W;
  localparam int SEL_W = (N_GPIO > 1) ? $clog2(N_GPIO) : 1;

  logic [11:0]                 addr;
  logic                        wr_en;
  logic                        rd_en;
  logic [1:0]                  bank;     // bank index of PIN/OUT offsets
  logic [SEL_W-1:0]            idx;      // pin index from write data
  logic                        idx_ok;
  logic [SEL_W-1:0]            sel;      // last selected pin
  logic [gpio_pkg::MAX_GPIO-1:0] pin_ext;
  logic [gpio_pkg::MAX_GPIO-1:0] out_ext;
  logic [DW-1:0]               rdata;

  assign addr    = 12'(PADDR);
  assign wr_en   = PSEL & PENABLE & PWRITE;
  assign rd_en   = PSEL & PENABLE & ~PWRITE;
  assign bank    = addr[3:2];
  assign idx     = PWDATA[SEL_W-1:0];
  assign idx_ok  = (int'(idx) < N_GPIO);

  assign PREADY  = 1'b1;  // no wait states
  assign PSLVERR = 1'b0;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sel      <= '0;
      out_reg  <= '0;
      dir_mode <= '0;
      int_type <= '0;
      int_en   <= '0;
    end else if (wr_en) begin
      case (addr)
        gpio_pkg::REG_SETSEL: begin
          if (idx_ok) sel <= idx;
        end
        gpio_pkg::REG_SETGPIO: begin
          if (idx_ok) begin
            out_reg[idx] <= 1'b1;
            sel          <= idx;
          end
        end
        gpio_pkg::REG_CLRGPIO: begin
          if (idx_ok) begin
            out_reg[idx] <= 1'b0;
            sel          <= idx;
          end
        end
        gpio_pkg::REG_TOGGPIO: begin
          if (idx_ok) begin
            out_reg[idx] <= ~out_reg[idx];
            sel          <= idx;
          end
        end
        gpio_pkg::REG_SETDIR: begin
          if (idx_ok) begin
            dir_mode[idx] <= PWDATA[gpio_pkg::FLD_DIR_LO +: 2];
            sel           <= idx;
          end
        end
        gpio_pkg::REG_SETINT: begin
          if (idx_ok) begin
            int_type[idx] <= PWDATA[gpio_pkg::FLD_INTTYPE_LO +: 3];
            int_en[idx]   <= PWDATA[gpio_pkg::FLD_INTEN];
            sel           <= idx;
          end
        end
        gpio_pkg::REG_OUT0,
        gpio_pkg::REG_OUT1,
        gpio_pkg::REG_OUT2,
        gpio_pkg::REG_OUT3: begin
          // bits above N_GPIO have no flop and drop out here
          for (int i = 0; i < N_GPIO; i++) begin
            if ((i / DW) == int'(bank)) out_reg[i] <= PWDATA[i % DW];
          end
        end
        default: ;  // unknown offset
      endcase
    end
  end

  // zero-extend to four full banks so every bank read is a plain slice
  always_comb begin
    pin_ext = '0;
    out_ext = '0;
    pin_ext[N_GPIO-1:0] = pin_sync;
    out_ext[N_GPIO-1:0] = out_reg;
  end

  always_comb begin
    rdata = '0;
    case (addr)
      gpio_pkg::REG_PIN0,
      gpio_pkg::REG_PIN1,
      gpio_pkg::REG_PIN2,
      gpio_pkg::REG_PIN3: begin
        rdata = pin_ext[bank*DW +: DW];
      end
      gpio_pkg::REG_OUT0,
      gpio_pkg::REG_OUT1,
      gpio_pkg::REG_OUT2,
      gpio_pkg::REG_OUT3: begin
        rdata = out_ext[bank*DW +: DW];
      end
      gpio_pkg::REG_RDSTAT: begin
        rdata[gpio_pkg::RD_DIR_LO +: 2]  = dir_mode[sel];
        rdata[gpio_pkg::RD_TYPE_LO +: 3] = int_type[sel];
        rdata[gpio_pkg::RD_IN_BIT]       = pin_sync[sel];
        rdata[gpio_pkg::RD_OUT_BIT]      = out_reg[sel];
        rdata[SEL_W-1:0]                 = sel;  // at most 7 bits, below RD_OUT_BIT
      end
      default: rdata = '0;
    endcase
  end

  // read data valid in the access phase itself
  assign PRDATA = rd_en ? rdata : '0;

endmodule

`default_nettype wire

//--- hw/gpio_pad_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_pad_ctrl #(
  parameter int N_GPIO = 32
) (
  input  wire logic [N_GPIO-1:0]      out_reg,
  input  wire logic [N_GPIO-1:0][1:0] dir_mode,
  output logic      [N_GPIO-1:0]      gpio_out,
  output logic      [N_GPIO-1:0]      gpio_dir
);

  always_comb begin
    for (int i = 0; i < N_GPIO; i++) begin
      case (dir_mode[i])
        gpio_pkg::DIR_PUSH: begin
          gpio_out[i] = out_reg[i];
          gpio_dir[i] = 1'b1;
        end
        gpio_pkg::DIR_OD: begin
          gpio_out[i] = 1'b0;  // only ever pulls low
          gpio_dir[i] = ~out_reg[i];
        end
        default: begin  // off, and unused code 11
          gpio_out[i] = 1'b0;
          gpio_dir[i] = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/gpio_irq_detect.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_irq_detect #(
  parameter int N_GPIO = 32
) (
  input  wire logic [N_GPIO-1:0]      pin_sync,
  input  wire logic [N_GPIO-1:0]      rise,
  input  wire logic [N_GPIO-1:0]      fall,
  input  wire logic [N_GPIO-1:0][2:0] int_type,
  input  wire logic [N_GPIO-1:0]      int_en,
  output logic      [N_GPIO-1:0]      interrupt
);

  logic [N_GPIO-1:0] is_fall;
  logic [N_GPIO-1:0] is_rise;
  logic [N_GPIO-1:0] is_level;
  logic [N_GPIO-1:0] level_hit;

  always_comb begin
    for (int i = 0; i < N_GPIO; i++) begin
      is_fall[i]  = int_type[i][0] & fall[i];
      is_rise[i]  = int_type[i][1] & rise[i];
      is_level[i] = (int_type[i][1:0] == 2'b00);  // no edge selected
      // bit 2 gives the active level, compared with the pin itself
      level_hit[i] = is_level[i] & ~(pin_sync[i] ^ int_type[i][2]);
    end
  end

  assign interrupt = int_en & (is_fall | is_rise | level_hit);

endmodule

`default_nettype wire

//--- hw/gpio_input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_input_sync #(
  parameter int N_GPIO = 32
) (
  input  wire logic              HCLK,
  input  wire logic              HRESETn,
  input  wire logic [N_GPIO-1:0] gpio_in,
  output logic      [N_GPIO-1:0] pin_sync,
  output logic      [N_GPIO-1:0] rise,
  output logic      [N_GPIO-1:0] fall
);

  logic [N_GPIO-1:0] meta0;
  logic [N_GPIO-1:0] meta1;
  logic [N_GPIO-1:0] chg;  // second flop differed from pin register

  // synchronizer chain into the pin register
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      meta0    <= '0;
      meta1    <= '0;
      pin_sync <= '0;
    end else begin
      meta0    <= gpio_in;
      meta1    <= meta0;
      pin_sync <= meta1;
    end
  end

  // The comparison is taken when the pin register loads the new value,
  // and qualified with the loaded value one edge later. The flags thus
  // trail gpio_in_sync by exactly one cycle and last one cycle.
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      chg  <= '0;
      rise <= '0;
      fall <= '0;
    end else begin
      chg  <= meta1 ^ pin_sync;
      rise <= chg & pin_sync;   // pin now high
      fall <= chg & ~pin_sync;  // pin now low
    end
  end

endmodule

`default_nettype wire

//--- hw/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

  localparam int APB_DATA_W = 32;
  localparam int MAX_GPIO   = 128;  // four banks of 32

  // per-pin commands, pin index in the low data bits
  localparam logic [11:0] REG_SETGPIO = 12'h000;
  localparam logic [11:0] REG_CLRGPIO = 12'h004;
  localparam logic [11:0] REG_TOGGPIO = 12'h008;

  localparam logic [11:0] REG_PIN0 = 12'h010;  // synchronized inputs
  localparam logic [11:0] REG_PIN1 = 12'h014;
  localparam logic [11:0] REG_PIN2 = 12'h018;
  localparam logic [11:0] REG_PIN3 = 12'h01C;

  localparam logic [11:0] REG_OUT0 = 12'h020;  // output value banks
  localparam logic [11:0] REG_OUT1 = 12'h024;
  localparam logic [11:0] REG_OUT2 = 12'h028;
  localparam logic [11:0] REG_OUT3 = 12'h02C;

  localparam logic [11:0] REG_SETSEL = 12'h030;
  localparam logic [11:0] REG_RDSTAT = 12'h034;
  localparam logic [11:0] REG_SETDIR = 12'h038;
  localparam logic [11:0] REG_SETINT = 12'h03C;

  // write data fields
  localparam int FLD_INTEN      = 16;
  localparam int FLD_INTTYPE_LO = 17;  // 19:17
  localparam int FLD_DIR_LO     = 24;  // 25:24

  // status word fields
  localparam int RD_DIR_LO  = 24;
  localparam int RD_TYPE_LO = 16;
  localparam int RD_IN_BIT  = 12;
  localparam int RD_OUT_BIT = 8;

  localparam logic [1:0] DIR_OFF  = 2'b00;
  localparam logic [1:0] DIR_PUSH = 2'b01;
  localparam logic [1:0] DIR_OD   = 2'b10;  // open drain

endpackage

`default_nettype wire
